//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_eeprom_ctrl
FILELIST  ?= eeprom_ctrl.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- design/eeprom_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_top #(
    parameter int HALF_PERIOD = 4   // CLK cycles per SCL half period
) (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     wr,
    input  logic                     rd,
    input  eeprom_pkg::eeprom_addr_t addr,
    input  i2c_pkg::byte_t           wdata,
    input  logic                     sda_in,
    output i2c_pkg::byte_t           rdata,
    output logic                     busy,
    output logic                     done,
    output logic                     nack,
    output logic                     scl,
    output logic                     sda_drive_low
);
    import i2c_pkg::*;

    byte_cmd_t cmd;
    byte_rsp_t rsp;
    bus_op_t   op;
    logic      op_done;
    logic      rx_bit;

    eeprom_seq u_seq (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .rsp   (rsp),
        .cmd   (cmd),
        .busy  (busy),
        .done  (done),
        .nack  (nack),
        .rdata (rdata)
    );

    i2c_byte_shifter u_shifter (
        .CLK     (CLK),
        .RESET   (RESET),
        .cmd     (cmd),
        .op_done (op_done),
        .rx_bit  (rx_bit),
        .op      (op),
        .rsp     (rsp)
    );

    i2c_bit_engine #(
        .HALF_PERIOD (HALF_PERIOD)
    ) u_bit_engine (
        .CLK           (CLK),
        .RESET         (RESET),
        .op            (op),
        .sda_in        (sda_in),
        .op_done       (op_done),
        .rx_bit        (rx_bit),
        .scl           (scl),
        .sda_drive_low (sda_drive_low)
    );

endmodule

`default_nettype wire

//--- design/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    typedef logic [10:0] eeprom_addr_t;   // 2 KB part

    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_WR,
        S_ADDR,
        S_DATA_WR,
        S_RESTART,
        S_CTRL_RD,
        S_DATA_RD,
        S_STOP,
        S_FINISH
    } seq_state_e;

endpackage

`default_nettype wire

//--- design/eeprom_seq.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_seq (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     wr,
    input  logic                     rd,
    input  eeprom_pkg::eeprom_addr_t addr,
    input  i2c_pkg::byte_t           wdata,
    input  i2c_pkg::byte_rsp_t       rsp,
    output i2c_pkg::byte_cmd_t       cmd,
    output logic                     busy,
    output logic                     done,
    output logic                     nack,
    output i2c_pkg::byte_t           rdata
);
    import i2c_pkg::*;
    import eeprom_pkg::*;

    seq_state_e   state;
    seq_state_e   state_after;
    eeprom_addr_t addr_q;
    byte_t        wdata_q;
    logic         is_read;
    logic         pending;    // command out and waiting for its done
    byte_cmd_t    cmd_next;
    logic         accept;

    assign busy   = (state != S_IDLE);
    assign done   = (state == S_FINISH);
    assign accept = (state == S_IDLE) && (wr || rd);

    // the one byte command that belongs to each state
    always_comb
    begin
        cmd_next       = '0;
        cmd_next.valid = 1'b1;
        case (state)
            S_START, S_RESTART:
                cmd_next.kind = CMD_START;
            S_CTRL_WR:
            begin
                cmd_next.kind = CMD_SEND;
                cmd_next.data = {DEVICE_CODE, addr_q[10:8], 1'b0};
            end
            S_ADDR:
            begin
                cmd_next.kind = CMD_SEND;
                cmd_next.data = addr_q[7:0];
            end
            S_DATA_WR:
            begin
                cmd_next.kind = CMD_SEND;
                cmd_next.data = wdata_q;
            end
            S_CTRL_RD:
            begin
                cmd_next.kind = CMD_SEND;
                cmd_next.data = {DEVICE_CODE, addr_q[10:8], 1'b1};
            end
            S_DATA_RD:
            begin
                cmd_next.kind        = CMD_RECV;
                cmd_next.master_nack = 1'b1;   // single byte read ends with nack
            end
            S_STOP:
                cmd_next.kind = CMD_STOP;
            default:
                cmd_next.valid = 1'b0;
        endcase
    end

    always_comb
    begin
        case (state)
            S_START:   state_after = S_CTRL_WR;
            S_CTRL_WR: state_after = S_ADDR;
            S_ADDR:    state_after = is_read ? S_RESTART : S_DATA_WR;
            S_RESTART: state_after = S_CTRL_RD;
            S_CTRL_RD: state_after = S_DATA_RD;
            S_STOP:    state_after = S_FINISH;
            default:   state_after = S_STOP;   // data write and data read
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            pending   <= 1'b0;
            nack      <= 1'b0;
            cmd.valid <= 1'b0;
        end
        else
        begin
            cmd.valid <= 1'b0;
            case (state)
                S_IDLE:
                    if (accept)
                    begin
                        nack  <= 1'b0;
                        state <= S_START;
                    end
                S_FINISH:
                    state <= S_IDLE;
                default:
                    if (!pending)
                    begin
                        cmd     <= cmd_next;
                        pending <= 1'b1;
                    end
                    else if (rsp.done)
                    begin
                        pending <= 1'b0;
                        if (cmd_next.kind == CMD_SEND && rsp.ack_bit)
                        begin
                            nack  <= 1'b1;   // abort
                            state <= S_STOP;
                        end
                        else
                            state <= state_after;
                    end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_q  <= addr;
            wdata_q <= wdata;
            is_read <= !wr;    // write wins
        end
        if (state == S_DATA_RD && pending && rsp.done)
            rdata <= rsp.data;
    end

    // shifter answers only the command in flight, and only once
    a_rsp_in_flight: assert property (@(posedge CLK) disable iff (RESET)
        rsp.done |-> pending);

endmodule

`default_nettype wire

//--- design/i2c_bit_engine.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_engine #(
    parameter int HALF_PERIOD = 4
) (
    input  logic             CLK,
    input  logic             RESET,
    input  i2c_pkg::bus_op_t op,
    input  logic             sda_in,
    output logic             op_done,
    output logic             rx_bit,
    output logic             scl,
    output logic             sda_drive_low
);
    import i2c_pkg::*;

    localparam int CNT_W = $clog2(HALF_PERIOD);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(HALF_PERIOD - 1);
    localparam logic [CNT_W-1:0] MID  = CNT_W'(HALF_PERIOD / 2 - 1);
    localparam logic [CNT_W-1:0] END1 = CNT_W'(HALF_PERIOD - 2);  // request cycle counts too

    logic             active;
    logic             phase;     // 0 = first half, 1 = second half
    logic [CNT_W-1:0] half_cnt;
    bus_op_e          cur_kind;
    logic             cur_bit;
    logic             is_bit;

    assign is_bit = (cur_kind == OP_WRITE_BIT) || (cur_kind == OP_READ_BIT);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active        <= 1'b0;
            phase         <= 1'b0;
            half_cnt      <= '0;
            op_done       <= 1'b0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
        end
        else
        begin
            op_done <= 1'b0;
            if (!active)
            begin
                if (op.valid)
                begin
                    active   <= 1'b1;
                    phase    <= 1'b0;
                    half_cnt <= '0;
                    scl      <= 1'b0;   // every op begins with SCL low
                    if (op.kind == OP_START)
                        sda_drive_low <= 1'b0;
                end
            end
            else if (!phase)
            begin
                // SDA moves one cycle after SCL has fallen
                if (half_cnt == '0)
                begin
                    if (cur_kind == OP_STOP)
                        sda_drive_low <= 1'b1;
                    else if (is_bit)
                        sda_drive_low <= (cur_kind == OP_WRITE_BIT) && !cur_bit;
                end
                if (half_cnt == MID && cur_kind == OP_START)
                    scl <= 1'b1;
                if (half_cnt == LAST)
                begin
                    phase    <= 1'b1;
                    half_cnt <= '0;
                    if (cur_kind == OP_START)
                        sda_drive_low <= 1'b1;   // start edge
                    else
                        scl <= 1'b1;
                end
                else
                    half_cnt <= half_cnt + 1'b1;
            end
            else
            begin
                if (half_cnt == MID && cur_kind == OP_STOP)
                    sda_drive_low <= 1'b0;       // stop edge
                if (half_cnt == END1)
                begin
                    active  <= 1'b0;
                    op_done <= 1'b1;
                    if (cur_kind == OP_START)
                        scl <= 1'b0;
                end
                else
                    half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!active && op.valid)
        begin
            cur_kind <= op.kind;
            cur_bit  <= op.bit_val;
        end
        if (active && phase && half_cnt == MID && cur_kind == OP_READ_BIT)
            rx_bit <= sda_in;   // middle of SCL high
    end

    // shifter must wait for op_done before the next op
    a_no_overlap: assert property (@(posedge CLK) disable iff (RESET)
        op.valid |-> !active);

    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (active && is_bit && scl) |-> $stable(sda_drive_low));

endmodule

`default_nettype wire

//--- design/i2c_byte_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_shifter (
    input  logic               CLK,
    input  logic               RESET,
    input  i2c_pkg::byte_cmd_t cmd,
    input  logic               op_done,
    input  logic               rx_bit,
    output i2c_pkg::bus_op_t   op,
    output i2c_pkg::byte_rsp_t rsp
);
    import i2c_pkg::*;

    logic       active;
    byte_cmd_e  cur_kind;
    logic       master_nack;
    byte_t      shreg;
    logic [3:0] bit_cnt;    // 8 down to 0, 0 is the ack slot
    logic       done_q;
    logic       ack_q;
    logic       last_op;

    assign rsp.done    = done_q;
    assign rsp.data    = shreg;    // the read byte once CMD_RECV is done
    assign rsp.ack_bit = ack_q;

    assign last_op = (cur_kind == CMD_START) || (cur_kind == CMD_STOP) || (bit_cnt == 4'd0);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active   <= 1'b0;
            done_q   <= 1'b0;
            op.valid <= 1'b0;
        end
        else
        begin
            done_q   <= 1'b0;
            op.valid <= 1'b0;
            if (cmd.valid)
            begin
                active     <= 1'b1;
                op.valid   <= 1'b1;
                op.bit_val <= cmd.data[7];   // MSB first
                case (cmd.kind)
                    CMD_START: op.kind <= OP_START;
                    CMD_STOP:  op.kind <= OP_STOP;
                    CMD_SEND:  op.kind <= OP_WRITE_BIT;
                    default:   op.kind <= OP_READ_BIT;
                endcase
            end
            else if (active && op_done)
            begin
                if (last_op)
                begin
                    active <= 1'b0;
                    done_q <= 1'b1;
                end
                else
                begin
                    op.valid <= 1'b1;
                    if (bit_cnt == 4'd1)
                    begin
                        // ninth bit goes the other way
                        op.kind    <= (cur_kind == CMD_SEND) ? OP_READ_BIT : OP_WRITE_BIT;
                        op.bit_val <= master_nack;
                    end
                    else
                    begin
                        op.kind    <= (cur_kind == CMD_SEND) ? OP_WRITE_BIT : OP_READ_BIT;
                        op.bit_val <= shreg[6];
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (cmd.valid)
        begin
            cur_kind    <= cmd.kind;
            shreg       <= cmd.data;
            master_nack <= cmd.master_nack;
            bit_cnt     <= 4'd8;
        end
        else if (active && op_done && bit_cnt != 4'd0)
        begin
            shreg   <= {shreg[6:0], rx_bit};   // out at the top, in at the bottom
            bit_cnt <= bit_cnt - 4'd1;
        end
        if (active && op_done && cur_kind == CMD_SEND && bit_cnt == 4'd0)
            ack_q <= rx_bit;
    end

    // sequencer issues the next command only after rsp.done
    a_one_cmd: assert property (@(posedge CLK) disable iff (RESET)
        cmd.valid |-> !active);

endmodule

`default_nettype wire

//--- design/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    typedef logic [7:0] byte_t;

    typedef enum logic [1:0] {
        OP_START,       // also the repeated start
        OP_STOP,
        OP_WRITE_BIT,
        OP_READ_BIT
    } bus_op_e;

    typedef struct packed {
        logic    valid;
        bus_op_e kind;
        logic    bit_val;
    } bus_op_t;

    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_SEND,       // 8 bits out, slave ack in
        CMD_RECV        // 8 bits in, master ack out
    } byte_cmd_e;

    typedef struct packed {
        logic      valid;
        byte_cmd_e kind;
        byte_t     data;
        logic      master_nack;
    } byte_cmd_t;

    typedef struct packed {
        logic  done;
        byte_t data;
        logic  ack_bit;    // 1 = slave did not ack
    } byte_rsp_t;

endpackage

`default_nettype wire

//--- eeprom_ctrl.f
design/i2c_pkg.sv
design/eeprom_pkg.sv
design/i2c_bit_engine.sv
design/i2c_byte_shifter.sv
design/eeprom_seq.sv
design/eeprom_ctrl_top.sv
verification/eeprom_model.sv
verification/tb_eeprom_ctrl.sv

//--- verification/eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic present,
    output logic sda_drive_low
);
    import i2c_pkg::*;
    import eeprom_pkg::*;

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_RDATA
    } mode_e;

    byte_t        mem [0:2047];
    mode_e        mode;
    logic [3:0]   bit_cnt;    // rising SCL edges in this byte, 9 = ack done
    byte_t        shreg;
    byte_t        tx;
    eeprom_addr_t addr_q;
    logic         scl_q;
    logic         sda_q;

    // contents survive reset, as in the real part
    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[11'(i)] = 8'(i) ^ 8'(i >> 3);
    end

    // bus lines are sampled on CLK, edges found against the previous sample
    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (RESET)
        begin
            mode          <= M_IDLE;
            bit_cnt       <= '0;
            sda_drive_low <= 1'b0;
        end
        else if (scl && scl_q && sda_q && !sda)
        begin
            mode          <= M_CTRL;   // start or repeated start
            bit_cnt       <= '0;
            sda_drive_low <= 1'b0;
        end
        else if (scl && scl_q && !sda_q && sda)
        begin
            mode          <= M_IDLE;   // stop
            sda_drive_low <= 1'b0;
        end
        else if (mode != M_IDLE && scl && !scl_q)
        begin
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt < 4'd8)
                shreg <= {shreg[6:0], sda};
        end
        else if (mode != M_IDLE && !scl && scl_q)
        begin
            case (bit_cnt)
                4'd8:
                    case (mode)
                        M_CTRL:
                            if (present && shreg[7:4] == DEVICE_CODE)
                            begin
                                addr_q[10:8]  <= shreg[3:1];
                                sda_drive_low <= 1'b1;
                            end
                        M_ADDR:
                        begin
                            addr_q[7:0]   <= shreg;
                            sda_drive_low <= 1'b1;
                        end
                        M_WDATA:
                        begin
                            mem[addr_q]   <= shreg;
                            sda_drive_low <= 1'b1;
                        end
                        default:
                            sda_drive_low <= 1'b0;   // master answers a read byte
                    endcase
                4'd9:
                begin
                    bit_cnt       <= '0;
                    sda_drive_low <= 1'b0;
                    case (mode)
                        M_CTRL:
                            if (!sda_drive_low)
                                mode <= M_IDLE;      // not addressed
                            else if (shreg[0])
                            begin
                                mode          <= M_RDATA;
                                tx            <= mem[addr_q];
                                sda_drive_low <= !mem[addr_q][7];
                            end
                            else
                                mode <= M_ADDR;
                        M_ADDR:
                            mode <= M_WDATA;
                        M_RDATA:
                            mode <= M_IDLE;          // single byte reads only
                        default:
                            ;
                    endcase
                end
                default:
                    if (mode == M_RDATA)
                        sda_drive_low <= !tx[3'(7 - bit_cnt)];
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_eeprom_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_ctrl;
    import i2c_pkg::*;
    import eeprom_pkg::*;

    localparam int HALF_PERIOD  = 4;
    localparam int N_TRANS      = 62;    // 2 + 16 + 40 + 2 + 2
    localparam int TRANS_CYCLES = 60 * 2 * HALF_PERIOD + 100;

    logic         CLK   = 1'b0;
    logic         RESET = 1'b1;
    logic         wr    = 1'b0;
    logic         rd    = 1'b0;
    eeprom_addr_t addr  = '0;
    byte_t        wdata = '0;
    logic         present = 1'b1;
    byte_t        rdata;
    logic         busy;
    logic         done;
    logic         nack;
    logic         scl;
    logic         sda_drive_low;
    logic         model_sda_low;
    logic         sda_line;
    byte_t        shadow [0:2047];

    assign sda_line = !(sda_drive_low || model_sda_low);   // open drain

    always #10 CLK = ~CLK;

    eeprom_ctrl_top #(
        .HALF_PERIOD (HALF_PERIOD)
    ) u_eeprom_ctrl_top (
        .CLK           (CLK),
        .RESET         (RESET),
        .wr            (wr),
        .rd            (rd),
        .addr          (addr),
        .wdata         (wdata),
        .sda_in        (sda_line),
        .rdata         (rdata),
        .busy          (busy),
        .done          (done),
        .nack          (nack),
        .scl           (scl),
        .sda_drive_low (sda_drive_low)
    );

    eeprom_model u_model (
        .CLK           (CLK),
        .RESET         (RESET),
        .scl           (scl),
        .sda           (sda_line),
        .present       (present),
        .sda_drive_low (model_sda_low)
    );

    // erased contents of the part mix the low address byte with the upper bits
    function automatic byte_t fill_byte(input eeprom_addr_t a);
        return a[7:0] ^ a[10:3];
    endfunction

    task automatic stop_with_failure();
        $display("Something failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string test, input string what,
                               input int expected, input int actual);
        assert (expected == actual)
        else
        begin
            $display("Error: %s %s expected %0h actual %0h", test, what, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic wait_done(output logic nack_seen);
        @(negedge CLK);
        while (!done)
            @(negedge CLK);
        nack_seen = nack;
    endtask

    task automatic write_byte(input eeprom_addr_t a, input byte_t d, output logic nack_seen);
        @(posedge CLK);
        #2;
        wr    = 1'b1;
        addr  = a;
        wdata = d;
        @(posedge CLK);
        #2;
        wr = 1'b0;
        wait_done(nack_seen);
    endtask

    task automatic read_byte(input eeprom_addr_t a, output byte_t d, output logic nack_seen);
        @(posedge CLK);
        #2;
        rd   = 1'b1;
        addr = a;
        @(posedge CLK);
        #2;
        rd = 1'b0;
        wait_done(nack_seen);
        d = rdata;
    endtask

    task automatic check_reset_state();
        @(negedge CLK);
        check_value("reset", "scl", 1, int'(scl));
        check_value("reset", "sda_drive_low", 0, int'(sda_drive_low));
        check_value("reset", "busy", 0, int'(busy));
        check_value("reset", "done", 0, int'(done));
        check_value("reset", "nack", 0, int'(nack));
    endtask

    task automatic write_then_read();
        byte_t got;
        logic  nk;
        write_byte(11'h123, 8'h5a, nk);
        shadow[11'h123] = 8'h5a;
        check_value("write_then_read", "write nack", 0, int'(nk));
        read_byte(11'h123, got, nk);
        check_value("write_then_read", "read nack", 0, int'(nk));
        check_value("write_then_read", "rdata", 'h5a, int'(got));
    endtask

    // same low byte in all eight blocks
    task automatic sweep_upper_address();
        byte_t got;
        logic  nk;
        for (int b = 0; b < 8; b++)
        begin
            write_byte({3'(b), 8'h3c}, {5'h15, 3'(b)}, nk);
            shadow[{3'(b), 8'h3c}] = {5'h15, 3'(b)};
            check_value("sweep_upper_address", "write nack", 0, int'(nk));
        end
        for (int b = 0; b < 8; b++)
        begin
            read_byte({3'(b), 8'h3c}, got, nk);
            check_value("sweep_upper_address", "read nack", 0, int'(nk));
            check_value("sweep_upper_address", $sformatf("rdata block %0d", b),
                        int'({5'h15, 3'(b)}), int'(got));
        end
    endtask

    task automatic random_traffic();
        eeprom_addr_t a;
        byte_t        d;
        byte_t        got;
        logic         nk;
        for (int n = 0; n < 40; n++)
        begin
            a = 11'($urandom);
            if (1'($urandom))
            begin
                d = 8'($urandom);
                write_byte(a, d, nk);
                shadow[a] = d;
                check_value("random_traffic", "write nack", 0, int'(nk));
            end
            else
            begin
                read_byte(a, got, nk);
                check_value("random_traffic", "read nack", 0, int'(nk));
                check_value("random_traffic", $sformatf("rdata at %h", a),
                            int'(shadow[a]), int'(got));
            end
        end
    endtask

    task automatic missing_device();
        byte_t got;
        logic  nk;
        @(posedge CLK);
        #2;
        present = 1'b0;
        write_byte(11'h2a5, 8'hc3, nk);
        check_value("missing_device", "write nack", 1, int'(nk));
        check_value("missing_device", "scl after write", 1, int'(scl));
        check_value("missing_device", "sda_drive_low after write", 0, int'(sda_drive_low));
        read_byte(11'h2a5, got, nk);
        check_value("missing_device", "read nack", 1, int'(nk));
        check_value("missing_device", "scl after read", 1, int'(scl));
        check_value("missing_device", "sda_drive_low after read", 0, int'(sda_drive_low));
        @(posedge CLK);
        #2;
        present = 1'b1;
    endtask

    task automatic ignore_busy_request();
        int    n_done;
        logic  busy_seen;
        logic  nk;
        byte_t got;
        @(posedge CLK);
        #2;
        wr    = 1'b1;
        addr  = 11'h5f0;
        wdata = 8'h96;
        @(posedge CLK);
        #2;
        wr = 1'b0;
        repeat (4) @(posedge CLK);
        #2;
        busy_seen = busy;
        rd        = 1'b1;   // should be dropped
        addr      = 11'h1f0;
        @(posedge CLK);
        #2;
        rd     = 1'b0;
        n_done = 0;
        nk     = 1'b1;
        while (n_done == 0)
        begin
            @(negedge CLK);
            if (done)
            begin
                n_done++;
                nk = nack;
            end
        end
        // long enough for a whole read to finish
        repeat (TRANS_CYCLES)
        begin
            @(negedge CLK);
            if (done)
                n_done++;
        end
        shadow[11'h5f0] = 8'h96;
        check_value("ignore_busy_request", "busy at read request", 1, int'(busy_seen));
        check_value("ignore_busy_request", "done pulses", 1, n_done);
        check_value("ignore_busy_request", "write nack", 0, int'(nk));
        check_value("ignore_busy_request", "busy after done", 0, int'(busy));
        read_byte(11'h5f0, got, nk);
        check_value("ignore_busy_request", "read nack", 0, int'(nk));
        check_value("ignore_busy_request", "rdata", 'h96, int'(got));
    endtask

    initial
    begin
        void'($urandom(32'hb45921e3));
        for (int i = 0; i < 2048; i++)
            shadow[11'(i)] = fill_byte(11'(i));
        repeat (8) @(posedge CLK);
        #2;
        RESET = 1'b0;
        check_reset_state();
        write_then_read();
        sweep_upper_address();
        random_traffic();
        missing_device();
        ignore_busy_request();
        $display("Everything OK");
        $finish;
    end

    initial
    begin
        repeat (N_TRANS * TRANS_CYCLES) @(posedge CLK);
        $display("watchdog expired, the transactions did not finish in time");
        stop_with_failure();
    end

endmodule

`default_nettype wire
